// File: logic/cpu_pkg.sv
// --------------------
// shared types for the 16-bit multicycle core; 8-bit branch offset in words
// undefined opcodes execute as no-ops, only the PC advances
// --------------------
package cpu_pkg;

  localparam int unsigned data_w    = 16;             // data and address width
  localparam int unsigned reg_cnt   = 8;              // r0..r7
  localparam int unsigned reg_idx_w = 3;

  localparam logic [data_w-1:0] pc_step  = 16'd2;     // byte addressed, 2 per instr
  localparam logic [data_w-1:0] reset_pc = 16'h0000;

  // instr[15:12]
  typedef enum logic [3:0] {
    op_add = 4'b0000,
    op_sub = 4'b0001,
    op_xor = 4'b0010,
    op_lli = 4'b1010,   // load low immediate, zero extended
    op_b   = 4'b1100,   // pc relative
    op_br  = 4'b1101,   // pc <= rs
    op_hlt = 4'b1111
  } opcode_e;

  // instr[11:9] of a branch
  typedef enum logic [2:0] {
    cond_ne = 3'b000,
    cond_eq = 3'b001,
    cond_gt = 3'b010,
    cond_lt = 3'b011,
    cond_ge = 3'b100,
    cond_le = 3'b101,
    cond_ov = 3'b110,
    cond_al = 3'b111
  } cond_e;

  typedef struct packed {
    opcode_e               opcode;
    logic [reg_idx_w-1:0]  rd;      // also LLI dest
    logic [reg_idx_w-1:0]  rs;      // also BR target reg
    logic [reg_idx_w-1:0]  rt;
    logic [2:0]            spare;
  } r_fmt_t;

  typedef struct packed {
    opcode_e     opcode;
    cond_e       cond;
    logic        spare;
    logic [7:0]  imm;               // branch offset or LLI value
  } b_fmt_t;

  // same fetched word, two views
  typedef union packed {
    r_fmt_t r_fmt;
    b_fmt_t b_fmt;
  } instr_u;

  typedef struct packed {
    logic v;   // bit 2
    logic n;
    logic z;   // bit 0
  } flags_t;

  typedef struct packed {
    logic                  valid;    // high in the exec cycle
    logic [data_w-1:0]     pc;       // pc of the retiring instr
    logic                  wr_en;
    logic [reg_idx_w-1:0]  wr_idx;
    logic [data_w-1:0]     wr_data;
  } retire_t;

endpackage

// File: logic/fetch_unit.sv
// --------------------
// one fetch in flight; start is ignored unless idle
// --------------------
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,       // one-cycle pulse from core_control
  input  logic [data_w-1:0] pc,
  input  logic              imem_ack,
  input  logic [data_w-1:0] imem_data,
  output logic              imem_req,
  output logic [data_w-1:0] imem_addr,
  output logic              fetch_done,  // pulse, instr valid from here on
  output instr_u            instr
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait_hi,   // req up, waiting for ack
    st_wait_lo    // req down, waiting for ack to drop
  } fetch_state_e;

  fetch_state_e state;

  // handshake control
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      imem_req   <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      fetch_done <= 1'b0;                 // pulse by default
      case (state)
        st_idle: begin
          if (start) begin
            imem_req <= 1'b1;             // addr registered in the same edge
            state    <= st_wait_hi;
          end
        end
        st_wait_hi: begin
          if (imem_ack) begin
            imem_req <= 1'b0;             // data captured below, release req
            state    <= st_wait_lo;
          end
        end
        st_wait_lo: begin
          if (!imem_ack) begin
            fetch_done <= 1'b1;           // full four-phase cycle closed
            state      <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // address and instruction registers
  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      imem_addr <= pc;                    // held until the next start
    end
    if (state == st_wait_hi && imem_ack) begin
      instr <= instr_u'(imem_data);
    end
  end

endmodule

// File: logic/core_control.sv
// --------------------
// fetch/exec sequencer; halt is sticky until rst
// --------------------
`timescale 1ns/1ps

module core_control import cpu_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   fetch_done,
  input  instr_u instr,
  output logic   start,     // kicks fetch_unit
  output logic   exec,      // single execute cycle
  output logic   halted
);

  typedef enum logic [1:0] {
    st_boot,    // first cycle out of reset
    st_fetch,   // fetch in flight
    st_exec,
    st_halt
  } ctrl_state_e;

  ctrl_state_e state;
  logic        is_hlt;

  assign is_hlt = (instr.r_fmt.opcode == op_hlt);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_boot;
      start <= 1'b0;
    end else begin
      start <= 1'b0;                  // one-cycle pulse
      case (state)
        st_boot: begin
          state <= st_fetch;
          start <= 1'b1;              // first req follows on the next edge
        end
        st_fetch: begin
          if (fetch_done) begin
            state <= st_exec;
          end
        end
        st_exec: begin
          if (is_hlt) begin
            state <= st_halt;         // no more fetches
          end else begin
            state <= st_fetch;
            start <= 1'b1;            // pc already updated by then
          end
        end
        st_halt: state <= st_halt;
        default: state <= st_boot;
      endcase
    end
  end

  assign exec   = (state == st_exec);
  assign halted = (state == st_halt);   // rises the cycle after HLT exec

endmodule

// File: logic/reg_file.sv
// --------------------
// r0 hardwired to zero, writes to it are dropped
// --------------------
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [reg_idx_w-1:0] rd_idx_a,
  input  logic [reg_idx_w-1:0] rd_idx_b,
  input  logic                 wr_en,
  input  logic [reg_idx_w-1:0] wr_idx,
  input  logic [data_w-1:0]    wr_data,
  output logic [data_w-1:0]    rd_data_a,
  output logic [data_w-1:0]    rd_data_b
);

  logic [data_w-1:0] regs [reg_cnt];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_cnt; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // async reads, no bypass needed since exec never overlaps a read-after-write
  assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
  assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

// File: logic/alu.sv
// --------------------
// ADD/SUB/XOR update flags, LLI writes without touching them
// --------------------
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 exec,
  input  instr_u               instr,
  input  logic [data_w-1:0]    src_a,     // rs
  input  logic [data_w-1:0]    src_b,     // rt
  output logic                 wr_en,
  output logic [reg_idx_w-1:0] wr_idx,
  output logic [data_w-1:0]    wr_data,
  output flags_t               flags
);

  localparam int unsigned msb = data_w - 1;

  logic [data_w-1:0] result;
  logic              ovf;
  logic              writes;     // opcode has a register result
  logic              sets_flags; // arithmetic or logic op

  always_comb begin
    result     = '0;
    ovf        = 1'b0;
    writes     = 1'b0;
    sets_flags = 1'b0;
    case (instr.r_fmt.opcode)
      op_add: begin
        result     = src_a + src_b;
        ovf        = (src_a[msb] == src_b[msb]) && (result[msb] != src_a[msb]);
        writes     = 1'b1;
        sets_flags = 1'b1;
      end
      op_sub: begin
        result     = src_a - src_b;
        ovf        = (src_a[msb] != src_b[msb]) && (result[msb] != src_a[msb]);
        writes     = 1'b1;
        sets_flags = 1'b1;
      end
      op_xor: begin
        result     = src_a ^ src_b;   // v stays clear
        writes     = 1'b1;
        sets_flags = 1'b1;
      end
      op_lli: begin
        result = {{(data_w-8){1'b0}}, instr.b_fmt.imm};
        writes = 1'b1;
      end
      default: ;                      // branches, halt, no-ops
    endcase
  end

  assign wr_en   = exec && writes;
  assign wr_idx  = instr.r_fmt.rd;
  assign wr_data = result;

  // flag register, read by pc_control on the next branch
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (exec && sets_flags) begin
      flags.v <= ovf;
      flags.n <= result[msb];
      flags.z <= (result == '0);
    end
  end

endmodule

// File: logic/pc_control.sv
// --------------------
// PC moves only on exec; offset is sign extended and counted in words
// --------------------
`timescale 1ns/1ps

module pc_control import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              exec,
  input  instr_u            instr,
  input  flags_t            flags,
  input  logic [data_w-1:0] branch_reg_addr,   // rs data
  output logic [data_w-1:0] pc
);

  logic              cond_ok;
  logic [data_w-1:0] pc_plus;     // fall-through
  logic [data_w-1:0] offset;      // sext(imm) << 1
  logic [data_w-1:0] target;
  logic [data_w-1:0] next_pc;

  // condition check against the flags of the last ALU op
  always_comb begin
    case (instr.b_fmt.cond)
      cond_ne: cond_ok = ~flags.z;
      cond_eq: cond_ok = flags.z;
      cond_gt: cond_ok = ~flags.z & ~flags.n;
      cond_lt: cond_ok = flags.n;
      cond_ge: cond_ok = flags.z | ~flags.n;
      cond_le: cond_ok = flags.n | flags.z;
      cond_ov: cond_ok = flags.v;
      cond_al: cond_ok = 1'b1;
      default: cond_ok = 1'b0;
    endcase
  end

  assign pc_plus = pc + pc_step;
  assign offset  = {{(data_w-9){instr.b_fmt.imm[7]}}, instr.b_fmt.imm, 1'b0};
  assign target  = pc_plus + offset;    // relative to pc+2

  always_comb begin
    next_pc = pc_plus;
    case (instr.r_fmt.opcode)
      op_b: begin
        if (cond_ok) begin
          next_pc = target;
        end
      end
      op_br: begin
        if (cond_ok) begin
          next_pc = branch_reg_addr;
        end
      end
      op_hlt:  next_pc = pc;            // parked on the HLT address
      default: next_pc = pc_plus;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (exec) begin
      pc <= next_pc;
    end
  end

endmodule

// File: logic/cpu_core.sv
// --------------------
// top level; imem port is a four-phase req/ack master
// --------------------
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              imem_ack,
  input  logic [data_w-1:0] imem_data,
  output logic              imem_req,
  output logic [data_w-1:0] imem_addr,
  output logic              halted,
  output retire_t           retire
);

  logic                 start;
  logic                 exec;
  logic                 fetch_done;
  instr_u               instr;
  logic [data_w-1:0]    pc;
  logic [data_w-1:0]    rd_data_a;     // rs
  logic [data_w-1:0]    rd_data_b;     // rt
  logic                 wr_en;
  logic [reg_idx_w-1:0] wr_idx;
  logic [data_w-1:0]    wr_data;
  flags_t               flags;

  fetch_unit u_fetch (
    .clk, .rst, .start, .pc,
    .imem_ack, .imem_data, .imem_req, .imem_addr,
    .fetch_done, .instr
  );

  core_control u_ctrl (
    .clk, .rst, .fetch_done, .instr,
    .start, .exec, .halted
  );

  reg_file u_regs (
    .clk, .rst,
    .rd_idx_a (instr.r_fmt.rs),
    .rd_idx_b (instr.r_fmt.rt),
    .wr_en, .wr_idx, .wr_data,
    .rd_data_a, .rd_data_b
  );

  alu u_alu (
    .clk, .rst, .exec, .instr,
    .src_a (rd_data_a),
    .src_b (rd_data_b),
    .wr_en, .wr_idx, .wr_data, .flags
  );

  pc_control u_pc (
    .clk, .rst, .exec, .instr, .flags,
    .branch_reg_addr (rd_data_a),     // BR target from rs
    .pc
  );

  // retire pc is the pre-update value, pc loads on the exec edge
  assign retire.valid   = exec;
  assign retire.pc      = pc;
  assign retire.wr_en   = wr_en;
  assign retire.wr_idx  = wr_idx;
  assign retire.wr_data = wr_data;

endmodule

// File: dv/tb_clock_gen.sv
// --------------------
// 40 ns clock; rst held high for 10 rising edges
// --------------------
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  localparam int half_ns      = 20;
  localparam int reset_cycles = 10;

  initial begin
    clk = 1'b0;
    forever #(half_ns) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;                  // released on a rising edge like the other inputs
  end

endmodule

// File: dv/cpu_core_tb.sv
// --------------------
// retire sequence checked against a hand-worked program table
// ack raise plus drop delay random, 0..5 cycles per fetch; test memory is 64 words
// --------------------
`timescale 1ns/1ps

module cpu_core_tb import cpu_pkg::*; ();

  typedef struct packed {
    logic [data_w-1:0]    pc;
    logic [data_w-1:0]    instr;
    logic                 wr_en;
    logic [reg_idx_w-1:0] wr_idx;
    logic [data_w-1:0]    wr_data;
  } step_t;

  logic              clk;
  logic              rst;
  logic              imem_ack;
  logic [data_w-1:0] imem_data;
  logic              imem_req;
  logic [data_w-1:0] imem_addr;
  logic              halted;
  retire_t           retire;

  step_t             steps[$];          // expected retires in order
  logic [data_w-1:0] mem [64];
  int unsigned       retired;
  int unsigned       ack_wait;          // cycles left before ack
  int unsigned       drop_wait;         // cycles left before ack drops
  logic              req_q;
  logic [data_w-1:0] addr_q;            // addr latched at req rise
  logic              first_req_done;

  tb_clock_gen u_clk (.clk, .rst);

  cpu_core i_dut (
    .clk, .rst, .imem_ack, .imem_data,
    .imem_req, .imem_addr, .halted, .retire
  );

  task automatic report_mismatch(string name, logic [15:0] got, logic [15:0] exp);
    $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_fault(string what);
    $display("error: %s at %0t", what, $time);
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic logic [15:0] r_word(opcode_e op, logic [2:0] rd, logic [2:0] rs,
                                         logic [2:0] rt);
    return {op, rd, rs, rt, 3'b000};
  endfunction

  // f3 is cond for B and rd for LLI
  function automatic logic [15:0] i_word(opcode_e op, logic [2:0] f3, int imm);
    return {op, f3, 1'b0, 8'(imm)};
  endfunction

  task automatic expect_write(logic [15:0] pc, logic [15:0] instr, logic [2:0] idx,
                              logic [15:0] data);
    step_t s;
    s = '{pc: pc, instr: instr, wr_en: 1'b1, wr_idx: idx, wr_data: data};
    steps.push_back(s);
  endtask

  task automatic expect_no_write(logic [15:0] pc, logic [15:0] instr);
    step_t s;
    s = '{pc: pc, instr: instr, wr_en: 1'b0, wr_idx: '0, wr_data: '0};
    steps.push_back(s);
  endtask

  task automatic build_program();
    expect_write(16'h00, i_word(op_lli, 3'd1, 5), 3'd1, 16'h0005);
    expect_write(16'h02, i_word(op_lli, 3'd2, 3), 3'd2, 16'h0003);
    expect_write(16'h04, r_word(op_add, 3'd3, 3'd1, 3'd2), 3'd3, 16'h0008);
    expect_write(16'h06, r_word(op_sub, 3'd4, 3'd2, 3'd1), 3'd4, 16'hfffe);  // 3 - 5
    expect_write(16'h08, r_word(op_xor, 3'd5, 3'd1, 3'd2), 3'd5, 16'h0006);
    expect_write(16'h0a, r_word(op_add, 3'd0, 3'd1, 3'd2), 3'd0, 16'h0008);  // into r0
    expect_write(16'h0c, r_word(op_add, 3'd6, 3'd0, 3'd1), 3'd6, 16'h0005);  // r0 reads 0
    // flags now z=0 n=0 v=0
    expect_no_write(16'h0e, i_word(op_b, cond_ne, 1));    // taken
    expect_no_write(16'h12, i_word(op_b, cond_eq, 1));
    expect_no_write(16'h14, i_word(op_b, cond_gt, 1));    // taken
    expect_no_write(16'h18, i_word(op_b, cond_lt, 1));
    expect_no_write(16'h1a, i_word(op_b, cond_ge, 1));    // taken
    expect_no_write(16'h1e, i_word(op_b, cond_le, 1));
    expect_no_write(16'h20, i_word(op_b, cond_ov, 1));
    expect_write(16'h22, r_word(op_sub, 3'd7, 3'd1, 3'd1), 3'd7, 16'h0000);  // z=1
    expect_no_write(16'h24, i_word(op_b, cond_ne, 1));
    expect_no_write(16'h26, i_word(op_b, cond_eq, 1));    // taken
    expect_no_write(16'h2a, i_word(op_b, cond_gt, 1));
    expect_no_write(16'h2c, i_word(op_b, cond_le, 1));    // taken
    expect_write(16'h30, r_word(op_sub, 3'd7, 3'd2, 3'd1), 3'd7, 16'hfffe);  // n=1
    expect_no_write(16'h32, i_word(op_b, cond_lt, 1));    // taken
    expect_no_write(16'h36, i_word(op_b, cond_ge, 1));
    // doubling loop runs twice over four ADDs and the last one overflows
    expect_write(16'h38, i_word(op_lli, 3'd3, 'hff), 3'd3, 16'h00ff);
    expect_write(16'h3a, r_word(op_add, 3'd3, 3'd3, 3'd3), 3'd3, 16'h01fe);
    expect_write(16'h3c, r_word(op_add, 3'd3, 3'd3, 3'd3), 3'd3, 16'h03fc);
    expect_write(16'h3e, r_word(op_add, 3'd3, 3'd3, 3'd3), 3'd3, 16'h07f8);
    expect_write(16'h40, r_word(op_add, 3'd3, 3'd3, 3'd3), 3'd3, 16'h0ff0);
    expect_no_write(16'h42, i_word(op_b, cond_gt, -5));   // back to 0x3a
    expect_write(16'h3a, r_word(op_add, 3'd3, 3'd3, 3'd3), 3'd3, 16'h1fe0);
    expect_write(16'h3c, r_word(op_add, 3'd3, 3'd3, 3'd3), 3'd3, 16'h3fc0);
    expect_write(16'h3e, r_word(op_add, 3'd3, 3'd3, 3'd3), 3'd3, 16'h7f80);
    expect_write(16'h40, r_word(op_add, 3'd3, 3'd3, 3'd3), 3'd3, 16'hff00);  // v=1 n=1
    expect_no_write(16'h42, i_word(op_b, cond_gt, -5));   // falls through
    expect_no_write(16'h44, i_word(op_b, cond_ov, 1));    // taken
    expect_write(16'h48, i_word(op_lli, 3'd5, 'h50), 3'd5, 16'h0050);
    expect_no_write(16'h4a, r_word(op_br, cond_eq, 3'd5, 3'd0));  // z=0 so it falls through
    expect_no_write(16'h4c, r_word(op_br, cond_al, 3'd5, 3'd0));  // to r5
    expect_no_write(16'h50, r_word(op_hlt, 3'd0, 3'd0, 3'd0));
  endtask

  task automatic load_memory();
    for (int i = 0; i < 64; i++) begin
      mem[i] = {4'hf, 6'(i), 6'(i)};    // halt words so that a stray fetch retires a wrong pc
    end
    foreach (steps[k]) begin
      mem[steps[k].pc[6:1]] = steps[k].instr;
    end
  endtask

  // instruction memory slave with a 5 cycle delay budget per fetch
  always @(posedge clk) begin
    int unsigned raise_delay;
    if (rst) begin
      imem_ack <= 1'b0;
    end else if (imem_req && !imem_ack) begin
      if (ack_wait == 0) begin
        if (imem_addr[data_w-1:7] != '0 || imem_addr[0]) begin
          report_fault("fetch address outside the test memory");
        end
        imem_ack  <= 1'b1;
        imem_data <= mem[imem_addr[6:1]];
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end else if (!imem_req && imem_ack) begin
      if (drop_wait == 0) begin
        raise_delay = $urandom % 6;
        imem_ack   <= 1'b0;             // phase 4
        ack_wait   <= raise_delay;
        drop_wait  <= $urandom % (6 - raise_delay);
      end else begin
        drop_wait <= drop_wait - 1;     // ack held high a little longer
      end
    end
  end

  // four-phase protocol monitor
  always @(posedge clk) begin
    if (rst) begin
      req_q          <= 1'b0;
      first_req_done <= 1'b0;
    end else begin
      if (imem_req && !req_q) begin
        assert (!imem_ack) else report_fault("imem_req rose while imem_ack was still high");
        if (!first_req_done) begin
          assert (imem_addr == 16'h0000)
            else report_mismatch("imem_addr", imem_addr, 16'h0000);
        end
        addr_q         <= imem_addr;
        first_req_done <= 1'b1;
      end else if (req_q || imem_ack) begin
        assert (imem_addr == addr_q) else report_mismatch("imem_addr", imem_addr, addr_q);
      end
      req_q <= imem_req;
    end
  end

  // retire checker
  always @(posedge clk) begin
    step_t exp_step;
    if (!rst && retire.valid) begin
      if (retired >= steps.size()) begin
        report_fault("an instruction retired after the end of the program");
      end else begin
        exp_step = steps[retired];
        assert (!halted) else report_fault("halted was high before HLT retired");
        assert (retire.pc == exp_step.pc)
          else report_mismatch("retire.pc", retire.pc, exp_step.pc);
        assert (retire.wr_en == exp_step.wr_en)
          else report_mismatch("retire.wr_en", 16'(retire.wr_en), 16'(exp_step.wr_en));
        if (exp_step.wr_en) begin
          assert (retire.wr_idx == exp_step.wr_idx)
            else report_mismatch("retire.wr_idx", 16'(retire.wr_idx), 16'(exp_step.wr_idx));
          assert (retire.wr_data == exp_step.wr_data)
            else report_mismatch("retire.wr_data", retire.wr_data, exp_step.wr_data);
        end
        retired <= retired + 1;
      end
    end
  end

  // watchdog allows 12 cycles for the slowest fetch plus exec
  initial begin
    wait (steps.size() != 0);
    repeat (steps.size() * 12 + 50) @(posedge clk);
    report_fault("timeout, the program did not halt in time");
  end

  initial begin
    int unsigned seed_draw;
    imem_ack  = 1'b0;
    imem_data = '0;
    retired   = 0;
    seed_draw = $urandom(32'hbc4c_0a87);
    ack_wait  = $urandom % 6;
    drop_wait = $urandom % (6 - ack_wait);
    build_program();
    load_memory();
    wait (retired == steps.size());
    @(posedge clk);
    assert (halted) else report_fault("halted did not rise the cycle after HLT");
    repeat (20) begin
      @(posedge clk);
      assert (!imem_req) else report_fault("a fetch was requested after HLT");
      assert (halted) else report_fault("halted dropped without a reset");
      assert (imem_addr == 16'h0050) else report_mismatch("imem_addr", imem_addr, 16'h0050);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: src.f
logic/cpu_pkg.sv
logic/fetch_unit.sv
logic/core_control.sv
logic/reg_file.sv
logic/alu.sv
logic/pc_control.sv
logic/cpu_core.sv
dv/tb_clock_gen.sv
dv/cpu_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the core and its testbench with Verilator, then run the simulation
# a $fatal in the testbench gives a non-zero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f src.f \
  --top-module cpu_core_tb \
  -o cpu_core_sim

./obj_dir/cpu_core_sim
